//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mrd
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS := mrd_consts.svh
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the simulator output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(BUILD_DIR)

//--- bank_divider_7.sv
`include "mrd_consts.svh"

module bank_divider_7 (
	input  logic [`MRD_ADDR_W-1:0] dividend,
	output logic [`MRD_ROW_W-1:0]  quotient,
	output logic [2:0]             remainder
);

	// floor(2^14 / 7), undershoots by at most one over the address range
	localparam logic [2*`MRD_ADDR_W-1:0] RECIP = 2340;
	localparam int SHIFT = 14;

	logic [2*`MRD_ADDR_W-1:0] prod;
	logic [`MRD_ADDR_W-1:0]   q_est;
	logic [`MRD_ADDR_W-1:0]   r_est;
	logic                     fix;

	assign prod  = dividend * RECIP;
	assign q_est = `MRD_ADDR_W'(prod >> SHIFT);
	assign r_est = dividend - q_est * 3'd7; // 0 .. 13
	assign fix   = (r_est >= 7);

	assign quotient  = `MRD_ROW_W'(fix ? q_est + 1'b1 : q_est);
	assign remainder = 3'(fix ? r_est - 3'd7 : r_est);

endmodule

//--- cta_addr_gen.sv
`include "mrd_consts.svh"

module cta_addr_gen
	import mrd_pkg::*;
(
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           enable,
	input  logic [2:0]                     num_factors,
	input  factor_t [`MRD_MAX_FACTORS-1:0] nf,
	output logic [`MRD_ADDR_W-1:0]         addr
);

	factor_t [`MRD_MAX_FACTORS-1:0]                  digit;
	factor_t [`MRD_MAX_FACTORS-1:0]                  digit_nxt;
	logic [`MRD_MAX_FACTORS-1:0][`MRD_ADDR_W-1:0]    weight;
	logic [`MRD_ADDR_W-1:0]                          addr_sum;

	// digit j is weighted by the product of all factors above it
	always_comb
	begin
		logic [`MRD_ADDR_W-1:0] acc;
		acc = 1;
		for (int j = `MRD_MAX_FACTORS - 1; j >= 0; j--)
		begin
			if (j < int'(num_factors))
			begin
				weight[j] = acc;
				acc = acc * `MRD_ADDR_W'(nf[j]);
			end
			else
				weight[j] = '0;
		end
	end

	// mixed-radix increment, digit 0 fastest
	always_comb
	begin
		logic carry;
		carry     = 1'b1;
		digit_nxt = digit;
		for (int j = 0; j < `MRD_MAX_FACTORS; j++)
		begin
			if (carry && (j < int'(num_factors)))
			begin
				if (digit[j] == nf[j] - 3'd1)
					digit_nxt[j] = '0;
				else
				begin
					digit_nxt[j] = digit[j] + 3'd1;
					carry        = 1'b0;
				end
			end
		end
	end

	always_comb
	begin
		addr_sum = '0;
		for (int j = 0; j < `MRD_MAX_FACTORS; j++)
			addr_sum = addr_sum + `MRD_ADDR_W'(digit[j]) * weight[j];
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n || !enable)
			digit <= '0;
		else
			digit <= digit_nxt;
		if (!rst_n)
			addr <= '0;
		else
			addr <= addr_sum;
	end

endmodule

//--- mrd_bank_ram.sv
`include "mrd_consts.svh"

module mrd_bank_ram
	import mrd_pkg::*;
(
	input  logic                  clk,
	input  bank_en_t              wr_en,
	input  logic [`MRD_ROW_W-1:0] wr_row,
	input  cplx_t                 wr_data,
	input  bank_en_t              rd_en,
	input  logic [`MRD_ROW_W-1:0] rd_row,
	output cplx_t [`MRD_BANKS-1:0] rd_data
);

	localparam int ROWS = (`MRD_MAX_PTS + `MRD_BANKS - 1) / `MRD_BANKS;

	for (genvar b = 0; b < `MRD_BANKS; b++)
	begin : g_bank
		cplx_t mem [ROWS];
		cplx_t q;

		always_ff @(posedge clk)
		begin
			if (wr_en[b])
				mem[wr_row] <= wr_data;
			if (rd_en[b])
				q <= mem[rd_row]; // holds its value between reads
		end

		assign rd_data[b] = q;
	end

endmodule

//--- mrd_consts.svh
`ifndef MRD_CONSTS_SVH
`define MRD_CONSTS_SVH

// memory organisation, sample i lives in bank i mod 7 at row i div 7
`define MRD_BANKS 7
`define MRD_ROW_W 9

// linear sample index and frame counters
`define MRD_ADDR_W 12

`define MRD_DATA_W 16 // per real / imaginary part

// frame configuration limits
`define MRD_MAX_FACTORS 6
`define MRD_MAX_PTS 2048

`endif

//--- mrd_ctrl.sv
`include "mrd_consts.svh"

module mrd_ctrl
	import mrd_pkg::*;
(
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                start,
	input  logic [`MRD_ADDR_W-1:0]              cfg_dftpts,
	input  logic [2:0]                          cfg_num_factors,
	input  factor_t [`MRD_MAX_FACTORS-1:0]      cfg_nf,
	input  logic                                sink_end,
	input  logic                                source_end,
	output mrd_state_e                          state,
	output mrd_state_e                          state_r,
	output logic [`MRD_ADDR_W-1:0]              dftpts,
	output logic [2:0]                          num_factors,
	output factor_t [`MRD_MAX_FACTORS-1:0]      nf,
	output logic                                busy,
	output logic                                done
);

	logic start_ok;

	assign start_ok = start && !busy && (state == st_idle);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state   <= st_idle;
			state_r <= st_idle;
			busy    <= 1'b0;
			done    <= 1'b0;
		end
		else
		begin
			state_r <= state;
			done    <= 1'b0;
			case (state)
			st_idle:
				if (start_ok)
					state <= st_sink;
			st_sink:
				if (sink_end)
					state <= st_wait_to_rd;
			st_wait_to_rd:
				state <= st_source; // banks hold the whole frame by now
			st_source:
				if (source_end)
				begin
					state <= st_idle;
					done  <= 1'b1;
				end
			default:
				state <= st_idle;
			endcase

			if (start_ok)
				busy <= 1'b1;
			else if (done)
				busy <= 1'b0;
		end
	end

	// frame configuration, held for the whole frame
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			dftpts      <= '0;
			num_factors <= '0;
			nf          <= '0;
		end
		else if (start_ok)
		begin
			dftpts      <= cfg_dftpts;
			num_factors <= cfg_num_factors;
			nf          <= cfg_nf;
		end
	end

	a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
		busy |-> !start)
		else $error("start pulsed while busy");

	a_sink_end_phase: assert property (@(posedge clk) disable iff (!rst_n)
		sink_end |-> (state == st_sink))
		else $error("sink_end outside the sink phase");

endmodule

//--- mrd_patterns.txt
// record: dftpts num_factors nf0 .. nf5 gap_mask, then the first four expected output indices
// then dftpts samples in natural order, imaginary part (real part is its complement); 0 ends
5 1 5 0 0 0 0 0 0  0 1 2 3
100 101 102 103 104
18 3 2 3 4 0 0 0 3  0 c 4 10
200 201 202 203 204 205 206 207 208 209 20a 20b 20c 20d 20e 20f 210 211 212 213 214 215 216 217
190 4 4 4 5 5 0 0 1  0 64 c8 12c
400 401 402 403 404 405 406 407 408 409 40a 40b 40c 40d 40e 40f 410 411 412 413 414 415 416 417
418 419 41a 41b 41c 41d 41e 41f 420 421 422 423 424 425 426 427 428 429 42a 42b 42c 42d 42e 42f
430 431 432 433 434 435 436 437 438 439 43a 43b 43c 43d 43e 43f 440 441 442 443 444 445 446 447
448 449 44a 44b 44c 44d 44e 44f 450 451 452 453 454 455 456 457 458 459 45a 45b 45c 45d 45e 45f
460 461 462 463 464 465 466 467 468 469 46a 46b 46c 46d 46e 46f 470 471 472 473 474 475 476 477
478 479 47a 47b 47c 47d 47e 47f 480 481 482 483 484 485 486 487 488 489 48a 48b 48c 48d 48e 48f
490 491 492 493 494 495 496 497 498 499 49a 49b 49c 49d 49e 49f 4a0 4a1 4a2 4a3 4a4 4a5 4a6 4a7
4a8 4a9 4aa 4ab 4ac 4ad 4ae 4af 4b0 4b1 4b2 4b3 4b4 4b5 4b6 4b7 4b8 4b9 4ba 4bb 4bc 4bd 4be 4bf
4c0 4c1 4c2 4c3 4c4 4c5 4c6 4c7 4c8 4c9 4ca 4cb 4cc 4cd 4ce 4cf 4d0 4d1 4d2 4d3 4d4 4d5 4d6 4d7
4d8 4d9 4da 4db 4dc 4dd 4de 4df 4e0 4e1 4e2 4e3 4e4 4e5 4e6 4e7 4e8 4e9 4ea 4eb 4ec 4ed 4ee 4ef
4f0 4f1 4f2 4f3 4f4 4f5 4f6 4f7 4f8 4f9 4fa 4fb 4fc 4fd 4fe 4ff 500 501 502 503 504 505 506 507
508 509 50a 50b 50c 50d 50e 50f 510 511 512 513 514 515 516 517 518 519 51a 51b 51c 51d 51e 51f
520 521 522 523 524 525 526 527 528 529 52a 52b 52c 52d 52e 52f 530 531 532 533 534 535 536 537
538 539 53a 53b 53c 53d 53e 53f 540 541 542 543 544 545 546 547 548 549 54a 54b 54c 54d 54e 54f
550 551 552 553 554 555 556 557 558 559 55a 55b 55c 55d 55e 55f 560 561 562 563 564 565 566 567
568 569 56a 56b 56c 56d 56e 56f 570 571 572 573 574 575 576 577 578 579 57a 57b 57c 57d 57e 57f
580 581 582 583 584 585 586 587 588 589 58a 58b 58c 58d 58e 58f
1e 3 5 3 2 0 0 0 3  0 6 c 12
600 601 602 603 604 605 606 607 608 609 60a 60b 60c 60d 60e 60f 610 611 612 613 614 615 616 617
618 619 61a 61b 61c 61d
0

//--- mrd_pkg.sv
`include "mrd_consts.svh"

package mrd_pkg;

	typedef enum logic [1:0] {
		st_idle       = 2'd0,
		st_sink       = 2'd1,
		st_wait_to_rd = 2'd2,
		st_source     = 2'd3
	} mrd_state_e;

	// one complex sample, re in the upper half
	typedef struct packed {
		logic signed [`MRD_DATA_W-1:0] re;
		logic signed [`MRD_DATA_W-1:0] im;
	} cplx_t;

	typedef logic [`MRD_BANKS-1:0] bank_en_t; // bit b selects bank b

	typedef logic [2:0] factor_t; // radix 2 to 5

endpackage

//--- mrd_sink.sv
`include "mrd_consts.svh"

module mrd_sink
	import mrd_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  mrd_state_e             state,
	input  logic [`MRD_ADDR_W-1:0] dftpts,
	input  logic                   in_valid,
	input  logic                   in_sop,
	input  cplx_t                  in_data,
	output bank_en_t               wr_en,
	output logic [`MRD_ROW_W-1:0]  wr_row,
	output cplx_t                  wr_data,
	output logic                   sink_end
);

	logic                   accept;
	logic [`MRD_ADDR_W-1:0] cnt;
	logic [`MRD_ADDR_W-1:0] wr_addr;
	logic [`MRD_ROW_W-1:0]  row;
	logic [2:0]             bank_idx;

	assign accept  = (state == st_sink) && in_valid;
	assign wr_addr = in_sop ? '0 : cnt; // sop restarts the frame

	bank_divider_7 u_div (
		.dividend  (wr_addr),
		.quotient  (row),
		.remainder (bank_idx)
	);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			cnt      <= '0;
			wr_en    <= '0;
			sink_end <= 1'b0;
		end
		else
		begin
			if (state != st_sink)
				cnt <= '0;
			else if (accept)
				cnt <= wr_addr + 1'b1;
			wr_en    <= accept ? (bank_en_t'(1) << bank_idx) : '0;
			sink_end <= accept && (wr_addr == dftpts - 1'b1);
		end
	end

	always_ff @(posedge clk)
	begin
		wr_row  <= row;
		wr_data <= in_data;
	end

	a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
		cnt <= dftpts)
		else $error("sink count ran past dftpts");

endmodule

//--- mrd_source.sv
`include "mrd_consts.svh"

module mrd_source
	import mrd_pkg::*;
(
	input  logic                           clk,
	input  logic                           rst_n,
	input  mrd_state_e                     state,
	input  mrd_state_e                     state_r,
	input  logic [`MRD_ADDR_W-1:0]         dftpts,
	input  logic [2:0]                     num_factors,
	input  factor_t [`MRD_MAX_FACTORS-1:0] nf,
	input  cplx_t [`MRD_BANKS-1:0]         rd_data,
	output bank_en_t                       rd_en,
	output logic [`MRD_ROW_W-1:0]          rd_row,
	output logic                           out_valid,
	output logic                           out_sop,
	output logic                           out_eop,
	output cplx_t                          out_data,
	output logic                           source_end
);

	logic                   entry;
	logic                   addr_en;
	logic [`MRD_ADDR_W-1:0] rd_cnt;
	logic [`MRD_ADDR_W-1:0] cta_addr;
	logic [`MRD_ROW_W-1:0]  row;
	logic [2:0]             bank_idx;
	logic [2:0]             bank_idx_r;
	logic [2:0]             bank_idx_rr;
	logic                   addr_vld;
	logic                   addr_sop;
	logic                   addr_eop;
	logic                   rd_vld;
	logic                   rd_sop;
	logic                   rd_eop;
	logic                   ram_vld;
	logic                   ram_sop;
	logic                   ram_eop;

	assign entry   = (state == st_source) && (state_r != st_source);
	assign addr_en = entry || (rd_cnt != '0);

	// ongoing read counter, the generator runs for exactly dftpts cycles
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			rd_cnt <= '0;
		else if (entry)
			rd_cnt <= 1;
		else if (rd_cnt != '0)
			rd_cnt <= (rd_cnt == dftpts - 1'b1) ? '0 : rd_cnt + 1'b1;
	end

	cta_addr_gen u_cta (
		.clk         (clk),
		.rst_n       (rst_n),
		.enable      (addr_en),
		.num_factors (num_factors),
		.nf          (nf),
		.addr        (cta_addr)
	);

	bank_divider_7 u_div (
		.dividend  (cta_addr),
		.quotient  (row),
		.remainder (bank_idx)
	);

	assign rd_en = rd_vld ? (bank_en_t'(1) << bank_idx_r) : '0;

	// valid / sop / eop follow the data through address, bank, ram and output stages
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			addr_vld   <= 1'b0;
			addr_sop   <= 1'b0;
			addr_eop   <= 1'b0;
			rd_vld     <= 1'b0;
			rd_sop     <= 1'b0;
			rd_eop     <= 1'b0;
			ram_vld    <= 1'b0;
			ram_sop    <= 1'b0;
			ram_eop    <= 1'b0;
			out_valid  <= 1'b0;
			out_sop    <= 1'b0;
			out_eop    <= 1'b0;
			source_end <= 1'b0;
		end
		else
		begin
			addr_vld   <= addr_en;
			addr_sop   <= entry;
			addr_eop   <= addr_en && (rd_cnt == dftpts - 1'b1);
			rd_vld     <= addr_vld;
			rd_sop     <= addr_sop;
			rd_eop     <= addr_eop;
			ram_vld    <= rd_vld;
			ram_sop    <= rd_sop;
			ram_eop    <= rd_eop;
			out_valid  <= ram_vld;
			out_sop    <= ram_sop;
			out_eop    <= ram_eop;
			source_end <= out_eop;
		end
	end

	always_ff @(posedge clk)
	begin
		bank_idx_r  <= bank_idx;
		rd_row      <= row;
		bank_idx_rr <= bank_idx_r; // lines up with the ram output
		out_data    <= rd_data[bank_idx_rr];
	end

	a_rd_in_source: assert property (@(posedge clk) disable iff (!rst_n)
		(rd_en != '0) |-> (state == st_source))
		else $error("bank read outside the source phase");

endmodule

//--- mrd_top.sv
`include "mrd_consts.svh"

module mrd_top
	import mrd_pkg::*;
(
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           start,
	input  logic [`MRD_ADDR_W-1:0]         dftpts,
	input  logic [2:0]                     num_factors,
	input  factor_t [`MRD_MAX_FACTORS-1:0] nf,
	input  logic                           in_valid,
	input  logic                           in_sop,
	input  cplx_t                          in_data,
	output logic                           busy,
	output logic                           out_valid,
	output logic                           out_sop,
	output logic                           out_eop,
	output cplx_t                          out_data,
	output logic                           done
);

	mrd_state_e                     state;
	mrd_state_e                     state_r;
	logic [`MRD_ADDR_W-1:0]         run_dftpts;
	logic [2:0]                     run_num_factors;
	factor_t [`MRD_MAX_FACTORS-1:0] run_nf;
	logic                           sink_end;
	logic                           source_end;
	bank_en_t                       wr_en;
	logic [`MRD_ROW_W-1:0]          wr_row;
	cplx_t                          wr_data;
	bank_en_t                       rd_en;
	logic [`MRD_ROW_W-1:0]          rd_row;
	cplx_t [`MRD_BANKS-1:0]         rd_data;

	mrd_ctrl u_ctrl (
		.clk             (clk),
		.rst_n           (rst_n),
		.start           (start),
		.cfg_dftpts      (dftpts),
		.cfg_num_factors (num_factors),
		.cfg_nf          (nf),
		.sink_end        (sink_end),
		.source_end      (source_end),
		.state           (state),
		.state_r         (state_r),
		.dftpts          (run_dftpts),
		.num_factors     (run_num_factors),
		.nf              (run_nf),
		.busy            (busy),
		.done            (done)
	);

	mrd_sink u_sink (
		.clk      (clk),
		.rst_n    (rst_n),
		.state    (state),
		.dftpts   (run_dftpts),
		.in_valid (in_valid),
		.in_sop   (in_sop),
		.in_data  (in_data),
		.wr_en    (wr_en),
		.wr_row   (wr_row),
		.wr_data  (wr_data),
		.sink_end (sink_end)
	);

	mrd_source u_source (
		.clk         (clk),
		.rst_n       (rst_n),
		.state       (state),
		.state_r     (state_r),
		.dftpts      (run_dftpts),
		.num_factors (run_num_factors),
		.nf          (run_nf),
		.rd_data     (rd_data),
		.rd_en       (rd_en),
		.rd_row      (rd_row),
		.out_valid   (out_valid),
		.out_sop     (out_sop),
		.out_eop     (out_eop),
		.out_data    (out_data),
		.source_end  (source_end)
	);

	mrd_bank_ram u_ram (
		.clk     (clk),
		.wr_en   (wr_en),
		.wr_row  (wr_row),
		.wr_data (wr_data),
		.rd_en   (rd_en),
		.rd_row  (rd_row),
		.rd_data (rd_data)
	);

endmodule

//--- sources.f
+incdir+.
mrd_pkg.sv
bank_divider_7.sv
cta_addr_gen.sv
mrd_bank_ram.sv
mrd_ctrl.sv
mrd_sink.sv
mrd_source.sv
mrd_top.sv
tb_mrd.sv

//--- tb_mrd.sv
`include "mrd_consts.svh"

module tb_mrd
	import mrd_pkg::*;
();

	localparam int PAT_WORDS = 1024;
	localparam int REC_HDR   = 13; // dftpts, num_factors, six factors, gap mask, four indices

	logic                           clk;
	logic                           rst_n;
	logic                           start;
	logic [`MRD_ADDR_W-1:0]         dftpts;
	logic [2:0]                     num_factors;
	factor_t [`MRD_MAX_FACTORS-1:0] nf;
	logic                           in_valid;
	logic                           in_sop;
	cplx_t                          in_data;
	logic                           busy;
	logic                           out_valid;
	logic                           out_sop;
	logic                           out_eop;
	cplx_t                          out_data;
	logic                           done;

	logic [31:0] pat [PAT_WORDS];
	logic [31:0] lfsr;
	int          fac [`MRD_MAX_FACTORS];
	int          exp_idx [`MRD_MAX_PTS];
	int          errors;
	int          frame_errors;
	int          frames;
	int          done_count = 0;
	int          cycles = 0;
	int          cycle_limit = 0;

	mrd_top dut_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (start),
		.dftpts      (dftpts),
		.num_factors (num_factors),
		.nf          (nf),
		.in_valid    (in_valid),
		.in_sop      (in_sop),
		.in_data     (in_data),
		.busy        (busy),
		.out_valid   (out_valid),
		.out_sop     (out_sop),
		.out_eop     (out_eop),
		.out_data    (out_data),
		.done        (done)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit)
		begin
			$display("timeout after %0d cycles, the frames never completed", cycles);
			$display("Test failed");
			$finish;
		end
	end

	always @(negedge clk)
		if (rst_n && done)
			done_count++;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32 + x^22 + x^2 + x + 1
	endfunction

	// idle cycles before a sample, two random bits masked by the frame's gap field
	task automatic draw_gap(input int mask, output int gap);
		gap = 0;
		for (int b = 0; b < 2; b++)
		begin
			lfsr = lfsr_next(lfsr);
			gap  = (gap << 1) | int'(lfsr[0]);
		end
		gap = gap & mask;
	endtask

	// output position c written as mixed-radix digits, then read back with the digits reversed
	function automatic int reversed_index(input int c, input int nfac);
		int rem;
		int idx;
		rem = c;
		idx = 0;
		for (int j = 0; j < nfac; j++)
		begin
			idx = idx * fac[j] + rem % fac[j];
			rem = rem / fac[j];
		end
		return idx;
	endfunction

	function automatic int budget_cycles();
		int p;
		int sum;
		p   = 0;
		sum = 0;
		while (p < PAT_WORDS && !$isunknown(pat[p]) && pat[p] != 0)
		begin
			sum += 2 * pat[p] + pat[p] * pat[p + 8] + 20; // worst-case gaps
			p   += REC_HDR + pat[p];
		end
		return 4 * sum;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		$display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
		frame_errors++;
	endtask

	task automatic run_frame(input int p, output int next_p);
		int          n;
		int          nfac;
		int          gap_mask;
		int          base;
		int          gap;
		logic [31:0] w;
		cplx_t       exp_data;
		n        = pat[p];
		nfac     = pat[p + 1];
		gap_mask = pat[p + 8];
		base     = p + REC_HDR;
		next_p   = base + n;
		frame_errors = 0;
		frames++;
		for (int j = 0; j < `MRD_MAX_FACTORS; j++)
			fac[j] = pat[p + 2 + j];
		for (int c = 0; c < n; c++)
			exp_idx[c] = reversed_index(c, nfac);
		for (int c = 0; c < 4; c++)
			if (exp_idx[c] != pat[p + 9 + c])
			begin
				$display("pattern file lists index %0d at output %0d, the digit reversal gives %0d",
					pat[p + 9 + c], c, exp_idx[c]);
				frame_errors++;
			end

		while (busy)
			@(negedge clk);
		@(posedge clk);
		start       <= 1'b1;
		dftpts      <= `MRD_ADDR_W'(n);
		num_factors <= 3'(nfac);
		for (int j = 0; j < `MRD_MAX_FACTORS; j++)
			nf[j] <= factor_t'(fac[j]);
		for (int i = 0; i < n; i++)
		begin
			if (i > 0)
			begin
				draw_gap(gap_mask, gap);
				repeat (gap)
				begin
					@(posedge clk);
					in_valid <= 1'b0;
					in_sop   <= 1'b0;
				end
			end
			w = pat[base + i];
			@(posedge clk);
			start      <= 1'b0;
			in_valid   <= 1'b1;
			in_sop     <= (i == 0);
			in_data.re <= ~w[15:0];
			in_data.im <= w[15:0];
		end
		@(posedge clk);
		in_valid <= 1'b0;
		in_sop   <= 1'b0;

		@(negedge clk);
		while (!out_valid)
			@(negedge clk);
		for (int c = 0; c < n; c++)
		begin
			w           = pat[base + exp_idx[c]];
			exp_data.re = ~w[15:0];
			exp_data.im = w[15:0];
			if (out_valid !== 1'b1)
				report_mismatch("out_valid", 1, 32'(out_valid));
			if (out_sop !== (c == 0))
				report_mismatch("out_sop", 32'(c == 0), 32'(out_sop));
			if (out_eop !== (c == n - 1))
				report_mismatch("out_eop", 32'(c == n - 1), 32'(out_eop));
			if (out_data !== exp_data)
				report_mismatch("out_data", exp_data, out_data);
			@(negedge clk);
		end
		if (out_valid !== 1'b0)
			report_mismatch("out_valid", 0, 32'(out_valid)); // stream longer than dftpts
		while (!done)
			@(negedge clk);
		if (busy !== 1'b1)
			report_mismatch("busy", 1, 32'(busy));
		@(negedge clk);
		if (busy !== 1'b0)
			report_mismatch("busy", 0, 32'(busy));
		$display("frame %0d: %0d points, %0d factors, gap mask %0d, %0d errors",
			frames, n, nfac, gap_mask, frame_errors);
		errors += frame_errors;
	endtask

	initial
	begin
		int p;
		int next_p;
		rst_n       = 1'b0;
		start       = 1'b0;
		dftpts      = '0;
		num_factors = '0;
		nf          = '0;
		in_valid    = 1'b0;
		in_sop      = 1'b0;
		in_data     = '0;
		lfsr        = 32'h8446;
		errors      = 0;
		frames      = 0;
		$readmemh("mrd_patterns.txt", pat);
		cycle_limit = budget_cycles();
		repeat (16)
			@(posedge clk);
		rst_n <= 1'b1;

		frame_errors = 0;
		repeat (4)
		begin
			@(negedge clk);
			if (busy !== 1'b0)
				report_mismatch("busy", 0, 32'(busy));
			if (done !== 1'b0)
				report_mismatch("done", 0, 32'(done));
			if (out_valid !== 1'b0)
				report_mismatch("out_valid", 0, 32'(out_valid));
			if (out_sop !== 1'b0)
				report_mismatch("out_sop", 0, 32'(out_sop));
			if (out_eop !== 1'b0)
				report_mismatch("out_eop", 0, 32'(out_eop));
		end
		$display("reset: outputs idle before the first start, %0d errors", frame_errors);
		errors += frame_errors;

		p = 0;
		while (p < PAT_WORDS && !$isunknown(pat[p]) && pat[p] != 0)
		begin
			run_frame(p, next_p);
			p = next_p;
		end
		if (frames == 0)
		begin
			$display("no frame records found in mrd_patterns.txt");
			errors++;
		end
		if (done_count != frames)
		begin
			$display("done pulsed %0d times over %0d frames", done_count, frames);
			errors++;
		end
		$display("%0d frames run, %0d errors", frames, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule
